// File: common/arp_crypto_pkg.sv
// Shared definitions for the ARP crypto packet steering block.
// Holds the stream widths, classification constants, FSM state
// encodings, the stream beat struct, the two-way tdata union and
// the byte counting helper used on tkeep.
package arp_crypto_pkg;

   localparam int data_width  = 256;
   localparam int keep_width  = 32;
   localparam int tuser_width = 128;

   // Destination-port byte in tuser that tags a payload packet
   localparam logic [7:0]  store_ident  = 8'hFF;
   // Ethertype as it appears in the stream byte order
   localparam logic [15:0] arp_type     = 16'h0608;
   localparam logic [31:0] magic_word   = 32'hA5A5A5A5;
   localparam logic [31:0] max_chunk    = 32'd1436;
   localparam logic [15:0] hdr_overhead = 16'd64;

   localparam int in_depth_bits    = 2;
   localparam int store_depth_bits = 4;

   // One-hot steering states
   localparam logic [5:0] st_idle        = 6'b000001;
   localparam logic [5:0] st_to_store    = 6'b000010;
   localparam logic [5:0] st_pass        = 6'b000100;
   localparam logic [5:0] st_arp_meta    = 6'b001000;
   localparam logic [5:0] st_arp_drain   = 6'b010000;
   localparam logic [5:0] st_arp_payload = 6'b100000;

   typedef struct packed {
      logic [data_width-1:0]  tdata;
      logic [keep_width-1:0]  tkeep;
      logic [tuser_width-1:0] tuser;
      logic                   tlast;
   } axis_beat_t;

   typedef union packed {
      // Ethernet header as seen on the first beat
      struct packed {
         logic [143:0] pad;
         logic [15:0]  eth_type;
         logic [47:0]  src_mac;
         logic [47:0]  dst_mac;
      } eth_view;
      // Metadata beat inserted after the ARP header
      struct packed {
         logic [79:0] pad;
         logic [31:0] size;
         logic [31:0] offset;
         logic [31:0] magic;
         logic [79:0] carry;
      } meta_view;
   } beat_data_u;

   // Valid bytes in a contiguous tkeep
   function automatic logic [5:0] keep_count(input logic [keep_width-1:0] keep);
      logic [5:0] n;
      n = '0;
      for (int i = 0; i < keep_width; i++) begin
         n = n + 6'(keep[i]);
      end
      return n;
   endfunction

endpackage

// File: rtl/beat_fifo.sv
// Fall-through FIFO of AXI-Stream beats.
// The head entry is always visible on dout, and nearly_full
// rises when only one free slot is left.
module beat_fifo #(
   parameter int depth_bits = 2
) (
   input  logic                       axis_aclk,
   input  logic                       axis_resetn,
   input  logic                       wr_en,
   input  arp_crypto_pkg::axis_beat_t din,
   input  logic                       rd_en,
   output arp_crypto_pkg::axis_beat_t dout,
   output logic                       empty,
   output logic                       nearly_full
);
   import arp_crypto_pkg::*;

   axis_beat_t             mem [(1 << depth_bits)];
   logic [depth_bits-1:0]  wr_ptr;
   logic [depth_bits-1:0]  rd_ptr;
   logic [depth_bits:0]    count;
   logic                   do_wr;
   logic                   do_rd;

   // Writes into a full buffer are ignored
   assign do_wr = wr_en && !count[depth_bits];
   assign do_rd = rd_en && !empty;

   assign dout        = mem[rd_ptr];
   assign empty       = (count == '0);
   assign nearly_full = (count >= (depth_bits + 1)'((1 << depth_bits) - 1));

   always_ff @(posedge axis_aclk) begin
      if (do_wr) begin
         mem[wr_ptr] <= din;
      end
   end

   always_ff @(posedge axis_aclk) begin
      if (!axis_resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count <= count + (depth_bits + 1)'(do_wr) - (depth_bits + 1)'(do_rd);
      end
   end

endmodule

// File: rtl/stream_stats.sv
// Stream statistics.
// Counts packets in and out with a sticky overflow bit in bit 31,
// and tracks how many payload bytes sit in the store.
module stream_stats (
   input  logic                                axis_aclk,
   input  logic                                axis_resetn,
   input  logic                                clear_counters,
   input  logic                                in_last_fire,
   input  logic                                out_last_fire,
   input  logic                                store_wr,
   input  logic [arp_crypto_pkg::keep_width-1:0] store_wr_keep,
   input  logic                                store_rd,
   input  logic [arp_crypto_pkg::keep_width-1:0] store_rd_keep,
   output logic [31:0]                         pkt_in,
   output logic [31:0]                         pkt_out,
   output logic [15:0]                         stored_bytes
);
   import arp_crypto_pkg::*;

   logic [15:0] bytes_added;
   logic [15:0] bytes_removed;

   // Low 31 bits count, the top bit latches a wrap
   function automatic logic [31:0] bump(input logic [31:0] cnt);
      logic [31:0] nxt;
      nxt[30:0] = cnt[30:0] + 31'd1;
      nxt[31]   = cnt[31] | (&cnt[30:0]);
      return nxt;
   endfunction

   assign bytes_added   = store_wr ? 16'(keep_count(store_wr_keep)) : 16'd0;
   assign bytes_removed = store_rd ? 16'(keep_count(store_rd_keep)) : 16'd0;

   always_ff @(posedge axis_aclk) begin
      if (!axis_resetn) begin
         pkt_in       <= '0;
         pkt_out      <= '0;
         stored_bytes <= '0;
      end else begin
         if (clear_counters) begin
            pkt_in  <= '0;
            pkt_out <= '0;
         end else begin
            if (in_last_fire) begin
               pkt_in <= bump(pkt_in);
            end
            if (out_last_fire) begin
               pkt_out <= bump(pkt_out);
            end
         end
         stored_bytes <= stored_bytes + bytes_added - bytes_removed;
      end
   end

endmodule

// File: arp_crypto/chunk_tracker.sv
// Transfer chunk tracker.
// Registers the configured total size and walks an offset through
// it, one chunk per ARP reply. A chunk is the smaller of max_chunk
// and the bytes still left.
module chunk_tracker (
   input  logic        axis_aclk,
   input  logic        axis_resetn,
   input  logic [31:0] cfg_size,
   input  logic        advance,
   output logic [31:0] size,
   output logic [31:0] offset,
   output logic [31:0] chunk
);
   import arp_crypto_pkg::*;

   logic [31:0] remain;

   assign remain = size - offset;
   assign chunk  = (remain < max_chunk) ? remain : max_chunk;

   always_ff @(posedge axis_aclk) begin
      if (!axis_resetn) begin
         size   <= '0;
         offset <= '0;
      end else begin
         size <= cfg_size;
         // Restart on a new size or once the whole transfer is done
         if (size != cfg_size || offset == size) begin
            offset <= '0;
         end else if (advance) begin
            offset <= offset + chunk;
         end
      end
   end

endmodule

// File: arp_crypto/packet_steer_fsm.sv
// Packet steering FSM.
// Classifies each head beat from the input FIFO and sends the packet
// to the payload store, straight through, or as an ARP reply that
// carries a metadata beat and the stored payload packet.
module packet_steer_fsm (
   input  logic                       axis_aclk,
   input  logic                       axis_resetn,
   input  arp_crypto_pkg::axis_beat_t in_head,
   input  logic                       in_empty,
   input  arp_crypto_pkg::axis_beat_t store_head,
   input  logic                       store_empty,
   input  logic                       store_nearly_full,
   input  logic                       m_axis_tready,
   input  logic [31:0]                size,
   input  logic [31:0]                offset,
   input  logic [31:0]                chunk,
   output logic                       in_rd,
   output logic                       store_wr,
   output arp_crypto_pkg::axis_beat_t store_din,
   output logic                       store_rd,
   output arp_crypto_pkg::axis_beat_t out_beat,
   output logic                       m_axis_tvalid,
   output logic                       advance
);
   import arp_crypto_pkg::*;

   logic [5:0]  state;
   logic [5:0]  next_state;
   beat_data_u  head_view;
   beat_data_u  meta;
   logic        is_store;
   logic        is_arp;

   assign head_view = in_head.tdata;
   assign is_store  = (in_head.tuser[23:16] == store_ident);
   // Reply only when a payload is waiting and the request has a second beat
   assign is_arp    = (head_view.eth_view.eth_type == arp_type) && !store_empty &&
                      !in_head.tlast;

   // Payload beats enter the store unchanged
   assign store_din = in_head;

   always_comb begin
      meta.meta_view.pad    = '0;
      meta.meta_view.size   = size;
      meta.meta_view.offset = offset;
      meta.meta_view.magic  = magic_word;
      meta.meta_view.carry  = in_head.tdata[79:0];
   end

   always_comb begin
      next_state    = state;
      in_rd         = 1'b0;
      store_wr      = 1'b0;
      store_rd      = 1'b0;
      m_axis_tvalid = 1'b0;
      advance       = 1'b0;
      out_beat      = in_head;

      case (state)
         st_idle: begin
            if (!in_empty) begin
               if (is_store) begin
                  if (!store_nearly_full) begin
                     store_wr = 1'b1;
                     in_rd    = 1'b1;
                     if (!in_head.tlast) begin
                        next_state = st_to_store;
                     end
                  end
               end else begin
                  m_axis_tvalid = 1'b1;
                  if (is_arp) begin
                     out_beat.tuser[15:0] = chunk[15:0] + hdr_overhead;
                  end
                  if (m_axis_tready) begin
                     in_rd = 1'b1;
                     if (is_arp) begin
                        next_state = st_arp_meta;
                     end else if (!in_head.tlast) begin
                        next_state = st_pass;
                     end
                  end
               end
            end
         end
         st_to_store: begin
            if (!in_empty && !store_nearly_full) begin
               store_wr = 1'b1;
               in_rd    = 1'b1;
               if (in_head.tlast) begin
                  next_state = st_idle;
               end
            end
         end
         st_pass: begin
            m_axis_tvalid = !in_empty;
            if (!in_empty && m_axis_tready) begin
               in_rd = 1'b1;
               if (in_head.tlast) begin
                  next_state = st_idle;
               end
            end
         end
         st_arp_meta: begin
            // Second request beat is replaced by the metadata word
            m_axis_tvalid  = !in_empty;
            out_beat.tdata = meta;
            out_beat.tkeep = '1;
            out_beat.tlast = 1'b0;
            if (!in_empty && m_axis_tready) begin
               in_rd   = 1'b1;
               advance = 1'b1;
               next_state = in_head.tlast ? st_arp_payload : st_arp_drain;
            end
         end
         st_arp_drain: begin
            // Rest of the request is dropped
            if (!in_empty) begin
               in_rd = 1'b1;
               if (in_head.tlast) begin
                  next_state = st_arp_payload;
               end
            end
         end
         st_arp_payload: begin
            m_axis_tvalid = !store_empty;
            out_beat      = store_head;
            if (!store_empty && m_axis_tready) begin
               store_rd = 1'b1;
               if (store_head.tlast) begin
                  next_state = st_idle;
               end
            end
         end
         default: begin
            next_state = st_idle;
         end
      endcase
   end

   always_ff @(posedge axis_aclk) begin
      if (!axis_resetn) begin
         state <= st_idle;
      end else begin
         state <= next_state;
      end
   end

endmodule

// File: arp_crypto/arp_crypto.sv
// ARP crypto packet steering, top level.
// Buffers incoming AXI-Stream beats, parks tagged payload packets in
// a store, and answers ARP requests with a header, a metadata beat
// and the next stored payload packet. Other traffic passes through.
module arp_crypto (
   input  logic                                    axis_aclk,
   input  logic                                    axis_resetn,
   input  logic [arp_crypto_pkg::data_width-1:0]   s_axis_tdata,
   input  logic [arp_crypto_pkg::keep_width-1:0]   s_axis_tkeep,
   input  logic [arp_crypto_pkg::tuser_width-1:0]  s_axis_tuser,
   input  logic                                    s_axis_tvalid,
   input  logic                                    s_axis_tlast,
   output logic                                    s_axis_tready,
   output logic [arp_crypto_pkg::data_width-1:0]   m_axis_tdata,
   output logic [arp_crypto_pkg::keep_width-1:0]   m_axis_tkeep,
   output logic [arp_crypto_pkg::tuser_width-1:0]  m_axis_tuser,
   output logic                                    m_axis_tvalid,
   output logic                                    m_axis_tlast,
   input  logic                                    m_axis_tready,
   input  logic [31:0]                             cfg_size,
   input  logic                                    clear_counters,
   output logic [31:0]                             pkt_in,
   output logic [31:0]                             pkt_out,
   output logic [15:0]                             stored_bytes
);
   import arp_crypto_pkg::*;

   axis_beat_t  s_beat;
   axis_beat_t  in_head;
   axis_beat_t  store_din;
   axis_beat_t  store_head;
   axis_beat_t  out_beat;
   logic        in_empty;
   logic        in_nearly_full;
   logic        in_rd;
   logic        store_wr;
   logic        store_rd;
   logic        store_empty;
   logic        store_nearly_full;
   logic        advance;
   logic [31:0] size;
   logic [31:0] offset;
   logic [31:0] chunk;

   assign s_beat.tdata  = s_axis_tdata;
   assign s_beat.tkeep  = s_axis_tkeep;
   assign s_beat.tuser  = s_axis_tuser;
   assign s_beat.tlast  = s_axis_tlast;
   assign s_axis_tready = !in_nearly_full;

   assign m_axis_tdata = out_beat.tdata;
   assign m_axis_tkeep = out_beat.tkeep;
   assign m_axis_tuser = out_beat.tuser;
   assign m_axis_tlast = out_beat.tlast;

   beat_fifo #(.depth_bits(in_depth_bits)) in_fifo (
      .axis_aclk   (axis_aclk),
      .axis_resetn (axis_resetn),
      .wr_en       (s_axis_tvalid && s_axis_tready),
      .din         (s_beat),
      .rd_en       (in_rd),
      .dout        (in_head),
      .empty       (in_empty),
      .nearly_full (in_nearly_full)
   );

   // Payload packets wait here for the next ARP request
   beat_fifo #(.depth_bits(store_depth_bits)) store_fifo (
      .axis_aclk   (axis_aclk),
      .axis_resetn (axis_resetn),
      .wr_en       (store_wr),
      .din         (store_din),
      .rd_en       (store_rd),
      .dout        (store_head),
      .empty       (store_empty),
      .nearly_full (store_nearly_full)
   );

   chunk_tracker u_chunk (
      .axis_aclk   (axis_aclk),
      .axis_resetn (axis_resetn),
      .cfg_size    (cfg_size),
      .advance     (advance),
      .size        (size),
      .offset      (offset),
      .chunk       (chunk)
   );

   packet_steer_fsm u_fsm (
      .axis_aclk         (axis_aclk),
      .axis_resetn       (axis_resetn),
      .in_head           (in_head),
      .in_empty          (in_empty),
      .store_head        (store_head),
      .store_empty       (store_empty),
      .store_nearly_full (store_nearly_full),
      .m_axis_tready     (m_axis_tready),
      .size              (size),
      .offset            (offset),
      .chunk             (chunk),
      .in_rd             (in_rd),
      .store_wr          (store_wr),
      .store_din         (store_din),
      .store_rd          (store_rd),
      .out_beat          (out_beat),
      .m_axis_tvalid     (m_axis_tvalid),
      .advance           (advance)
   );

   stream_stats u_stats (
      .axis_aclk      (axis_aclk),
      .axis_resetn    (axis_resetn),
      .clear_counters (clear_counters),
      .in_last_fire   (s_axis_tvalid && s_axis_tready && s_axis_tlast),
      .out_last_fire  (m_axis_tvalid && m_axis_tready && m_axis_tlast),
      .store_wr       (store_wr),
      .store_wr_keep  (store_din.tkeep),
      .store_rd       (store_rd),
      .store_rd_keep  (store_head.tkeep),
      .pkt_in         (pkt_in),
      .pkt_out        (pkt_out),
      .stored_bytes   (stored_bytes)
   );

endmodule

// File: bench/tb_arp_crypto.sv
// Testbench for the ARP crypto packet steering block.
// Drives pass-through, payload and ARP traffic, keeps a model of the
// expected output stream, and checks each output handshake and the
// status counters.
module tb_arp_crypto;
   import arp_crypto_pkg::*;

   localparam int          clk_period = 20;
   localparam int          max_beats  = 120;
   localparam int          timeout    = (max_beats * 40 + 2000) * clk_period;
   localparam logic [31:0] lcg_seed   = 32'hf658_863d;

   logic                   axis_aclk;
   logic                   axis_resetn;
   logic [data_width-1:0]  s_axis_tdata;
   logic [keep_width-1:0]  s_axis_tkeep;
   logic [tuser_width-1:0] s_axis_tuser;
   logic                   s_axis_tvalid;
   logic                   s_axis_tlast;
   logic                   s_axis_tready;
   logic [data_width-1:0]  m_axis_tdata;
   logic [keep_width-1:0]  m_axis_tkeep;
   logic [tuser_width-1:0] m_axis_tuser;
   logic                   m_axis_tvalid;
   logic                   m_axis_tlast;
   logic                   m_axis_tready;
   logic [31:0]            cfg_size;
   logic                   clear_counters;
   logic [31:0]            pkt_in;
   logic [31:0]            pkt_out;
   logic [15:0]            stored_bytes;

   int          errors = 0;
   int          checks = 0;
   logic [31:0] lcg_data;
   logic [31:0] lcg_bp;
   logic        bp_on;
   axis_beat_t  exp_q[$];
   bit          user_q[$];
   axis_beat_t  store_q[$];
   int          store_len_q[$];
   logic [31:0] model_size;
   logic [31:0] model_offset;
   int          model_bytes;

   arp_crypto uut (
      .axis_aclk      (axis_aclk),
      .axis_resetn    (axis_resetn),
      .s_axis_tdata   (s_axis_tdata),
      .s_axis_tkeep   (s_axis_tkeep),
      .s_axis_tuser   (s_axis_tuser),
      .s_axis_tvalid  (s_axis_tvalid),
      .s_axis_tlast   (s_axis_tlast),
      .s_axis_tready  (s_axis_tready),
      .m_axis_tdata   (m_axis_tdata),
      .m_axis_tkeep   (m_axis_tkeep),
      .m_axis_tuser   (m_axis_tuser),
      .m_axis_tvalid  (m_axis_tvalid),
      .m_axis_tlast   (m_axis_tlast),
      .m_axis_tready  (m_axis_tready),
      .cfg_size       (cfg_size),
      .clear_counters (clear_counters),
      .pkt_in         (pkt_in),
      .pkt_out        (pkt_out),
      .stored_bytes   (stored_bytes)
   );

   initial begin
      axis_aclk = 1'b0;
      forever #(clk_period / 2) axis_aclk = ~axis_aclk;
   end

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic note_error(input string msg);
      errors++;
      $display("Error at time %0t: %s", $time, msg);
   endtask

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] want);
      checks++;
      assert (got == want) else note_error($sformatf("%s is %0d, expected %0d", what, got, want));
   endtask

   // Random beat with a chosen port byte and Ethertype and a trimmed last beat
   task automatic random_beat(output axis_beat_t b, input logic [7:0] port,
                              input logic [15:0] eth, input logic last, output int nbytes);
      logic [4:0] trim;
      for (int i = 0; i < 8; i++) begin
         lcg_data = lcg_step(lcg_data);
         b.tdata[i*32 +: 32] = lcg_data;
      end
      for (int i = 0; i < 4; i++) begin
         lcg_data = lcg_step(lcg_data);
         b.tuser[i*32 +: 32] = lcg_data;
      end
      b.tdata[111:96] = eth;
      b.tuser[23:16]  = port;
      trim            = last ? lcg_data[27:23] : 5'd0;
      b.tkeep         = {keep_width{1'b1}} >> trim;
      b.tlast         = last;
      nbytes          = keep_width - int'(trim);
   endtask

   // Hold the beat on s_axis until a cycle with tready high
   task automatic drive_beat(input axis_beat_t b);
      logic taken;
      s_axis_tdata  = b.tdata;
      s_axis_tkeep  = b.tkeep;
      s_axis_tuser  = b.tuser;
      s_axis_tlast  = b.tlast;
      s_axis_tvalid = 1'b1;
      taken         = 1'b0;
      while (!taken) begin
         @(negedge axis_aclk);
         taken = s_axis_tready;
         @(posedge axis_aclk);
         #2;
      end
      s_axis_tvalid = 1'b0;
   endtask

   task automatic send_plain(input int nbeats, input logic [15:0] eth);
      axis_beat_t b;
      int         nbytes;
      for (int i = 0; i < nbeats; i++) begin
         random_beat(b, {1'b0, lcg_data[22:16]}, eth, i == nbeats - 1, nbytes);
         exp_q.push_back(b);
         user_q.push_back(1'b1);
         drive_beat(b);
      end
   endtask

   task automatic send_payload(input int nbeats);
      axis_beat_t b;
      int         nbytes;
      for (int i = 0; i < nbeats; i++) begin
         random_beat(b, store_ident, 16'h0008, i == nbeats - 1, nbytes);
         store_q.push_back(b);
         store_len_q.push_back(nbytes);
         model_bytes += nbytes;
         drive_beat(b);
      end
   endtask

   // Reply is header, metadata beat, then one stored packet
   task automatic send_arp(input int nbeats);
      axis_beat_t  b;
      axis_beat_t  s;
      axis_beat_t  req_q[$];
      beat_data_u  md;
      logic [31:0] chunk;
      int          nbytes;
      if (store_q.size() == 0) begin
         send_plain(nbeats, 16'h0608);
      end else begin
         chunk = model_size - model_offset;
         if (chunk > 32'd1436) begin
            chunk = 32'd1436;
         end
         for (int i = 0; i < nbeats; i++) begin
            random_beat(b, {1'b0, lcg_data[22:16]}, 16'h0608, i == nbeats - 1, nbytes);
            req_q.push_back(b);
            s = b;
            if (i == 0) begin
               s.tuser[15:0] = chunk[15:0] + 16'd64;
               exp_q.push_back(s);
               user_q.push_back(1'b1);
            end else if (i == 1) begin
               md.meta_view.pad    = '0;
               md.meta_view.size   = model_size;
               md.meta_view.offset = model_offset;
               md.meta_view.magic  = 32'hA5A5A5A5;
               md.meta_view.carry  = b.tdata[79:0];
               s.tdata = md;
               s.tkeep = {keep_width{1'b1}};
               s.tlast = 1'b0;
               exp_q.push_back(s);
               user_q.push_back(1'b0);
            end
         end
         do begin
            s = store_q.pop_front();
            model_bytes -= store_len_q.pop_front();
            exp_q.push_back(s);
            user_q.push_back(1'b1);
         end while (!s.tlast);
         model_offset = model_offset + chunk;
         if (model_offset == model_size) begin
            model_offset = '0;
         end
         foreach (req_q[i]) begin
            drive_beat(req_q[i]);
         end
      end
   endtask

   // Wait until the model queue and the input buffer are drained
   task automatic wait_idle();
      @(negedge axis_aclk);
      while (exp_q.size() != 0 || !uut.in_empty) begin
         @(negedge axis_aclk);
      end
      repeat (2) @(posedge axis_aclk);
      #2;
   endtask

   task automatic pulse_clear();
      clear_counters = 1'b1;
      @(posedge axis_aclk);
      #2;
      clear_counters = 1'b0;
   endtask

   // One output check per handshake
   always @(negedge axis_aclk) begin
      axis_beat_t want;
      bit         user_chk;
      if (axis_resetn && m_axis_tvalid && m_axis_tready) begin
         checks++;
         if (exp_q.size() == 0) begin
            note_error("an output beat arrived while none was expected");
         end else begin
            want     = exp_q.pop_front();
            user_chk = user_q.pop_front();
            assert (m_axis_tdata == want.tdata)
               else note_error($sformatf("tdata %h, expected %h", m_axis_tdata, want.tdata));
            assert (m_axis_tkeep == want.tkeep)
               else note_error($sformatf("tkeep %h, expected %h", m_axis_tkeep, want.tkeep));
            assert (!user_chk || m_axis_tuser == want.tuser)
               else note_error($sformatf("tuser %h, expected %h", m_axis_tuser, want.tuser));
            assert (m_axis_tlast == want.tlast)
               else note_error($sformatf("tlast %b, expected %b", m_axis_tlast, want.tlast));
         end
      end
   end

   hold_check: assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
      (m_axis_tvalid && !m_axis_tready) |=>
      (m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tkeep) &&
       $stable(m_axis_tuser) && $stable(m_axis_tlast)))
      else note_error("output beat dropped or changed while stalled");

   // Random back-pressure on m_axis
   initial begin
      lcg_bp        = lcg_seed;
      m_axis_tready = 1'b1;
      forever begin
         @(posedge axis_aclk);
         #2;
         if (bp_on) begin
            lcg_bp        = lcg_step(lcg_bp);
            m_axis_tready = (lcg_bp[31:30] != 2'b00);
         end else begin
            m_axis_tready = 1'b1;
         end
      end
   end

   initial begin
      #(timeout);
      $display("Timeout: the run did not finish within %0d time units", timeout);
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("CHECKS FAILED");
      $finish;
   end

   initial begin
      lcg_data       = lcg_seed;
      bp_on          = 1'b0;
      model_size     = 32'd3000;
      model_offset   = '0;
      model_bytes    = 0;
      axis_resetn    = 1'b0;
      s_axis_tdata   = '0;
      s_axis_tkeep   = '0;
      s_axis_tuser   = '0;
      s_axis_tvalid  = 1'b0;
      s_axis_tlast   = 1'b0;
      cfg_size       = 32'd3000;
      clear_counters = 1'b0;
      repeat (3) @(posedge axis_aclk);
      #2;
      axis_resetn = 1'b1;
      @(posedge axis_aclk);
      #2;
      check_value("s_axis_tready after reset", 32'(s_axis_tready), 32'd1);
      check_value("m_axis_tvalid after reset", 32'(m_axis_tvalid), 32'd0);
      check_value("stored_bytes after reset", 32'(stored_bytes), 32'd0);

      // Plain packets pass unchanged
      for (int i = 0; i < 6; i++) begin
         lcg_data = lcg_step(lcg_data);
         send_plain(1 + int'(lcg_data[31:30]), 16'h0008);
      end
      wait_idle();
      check_value("pkt_in after plain traffic", pkt_in, 32'd6);
      check_value("pkt_out after plain traffic", pkt_out, 32'd6);

      // Payload is parked, then returned by an ARP request
      pulse_clear();
      send_payload(3);
      wait_idle();
      check_value("pkt_in after payload", pkt_in, 32'd1);
      check_value("pkt_out after payload", pkt_out, 32'd0);
      check_value("stored_bytes after payload", 32'(stored_bytes), 32'(model_bytes));
      send_arp(3);
      wait_idle();
      check_value("pkt_in after reply", pkt_in, 32'd2);
      check_value("pkt_out after reply", pkt_out, 32'd1);
      check_value("stored_bytes after reply", 32'(stored_bytes), 32'd0);

      // Offset walks 1436, 2872, then wraps to 0
      for (int i = 0; i < 3; i++) begin
         lcg_data = lcg_step(lcg_data);
         send_payload(1 + int'(lcg_data[31]));
         send_arp(2 + int'(lcg_data[30]));
         wait_idle();
      end

      // New size restarts the offset
      cfg_size     = 32'd5000;
      model_size   = 32'd5000;
      model_offset = '0;
      repeat (2) @(posedge axis_aclk);
      #2;
      send_payload(2);
      send_arp(2);
      wait_idle();
      check_value("stored_bytes after new size", 32'(stored_bytes), 32'd0);

      // ARP with an empty store passes through
      send_arp(2);
      wait_idle();

      // Mixed traffic under back-pressure
      pulse_clear();
      bp_on = 1'b1;
      for (int i = 0; i < 10; i++) begin
         lcg_data = lcg_step(lcg_data);
         if (i == 4) begin
            send_payload(2);
         end else if (i == 6) begin
            send_arp(3);
         end else begin
            send_plain(1 + int'(lcg_data[31:30]), 16'h0008);
         end
      end
      wait_idle();
      check_value("pkt_in under back-pressure", pkt_in, 32'd10);
      check_value("pkt_out under back-pressure", pkt_out, 32'd9);
      bp_on = 1'b0;
      pulse_clear();
      check_value("pkt_in after clear", pkt_in, 32'd0);
      check_value("pkt_out after clear", pkt_out, 32'd0);

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

// File: sim.f
common/arp_crypto_pkg.sv
rtl/beat_fifo.sv
rtl/stream_stats.sv
arp_crypto/chunk_tracker.sv
arp_crypto/packet_steer_fsm.sv
arp_crypto/arp_crypto.sv
bench/tb_arp_crypto.sv

// File: Makefile
# Verilator simulation of the ARP crypto testbench

VERILATOR ?= verilator
TOP       ?= tb_arp_crypto
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "CHECKS FAILED" >> $(LOG)
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@echo "Simulation log is clean"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
